// File: Bender.yml
package:
  name: qdr_controller

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/qdr_pkg.sv
      - rtl/qdr_phy_init.sv
      - rtl/qdr_cmd_issue.sv
      - rtl/qdr_rd_capture.sv
      - rtl/qdr_controller.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/qdr_sram_model.sv
      - bench/qdr_controller_chk.sv
      - bench/qdr_controller_tb.sv

// File: bench/qdr_controller_chk.sv
module qdr_controller_chk (
  input logic clk0,
  input logic rst_i,
  input logic qdr_w_n,
  input logic qdr_r_n,
  input logic slot,
  input logic usr_rd_strb,
  input logic usr_wr_strb,
  input logic phy_rdy,
  input logic usr_rd_dvld
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;

  a_rw_excl: assert property (@(posedge clk0) disable iff (rst_i) !(!qdr_w_n && !qdr_r_n))
    else begin $error("w_n and r_n low together"); fail_cnt++; end
  a_w_slot: assert property (@(posedge clk0) disable iff (rst_i) !qdr_w_n |-> slot)
    else begin $error("write outside its slot"); fail_cnt++; end
  a_r_slot: assert property (@(posedge clk0) disable iff (rst_i) !qdr_r_n |-> !slot)
    else begin $error("read outside its slot"); fail_cnt++; end
  a_strb_rdy: assert property (@(posedge clk0) disable iff (rst_i)
                               (usr_rd_strb || usr_wr_strb) |-> phy_rdy)
    else begin $error("user strobe before phy_rdy"); fail_cnt++; end
  a_rd_space: assert property (@(posedge clk0) disable iff (rst_i) usr_rd_strb |=> !usr_rd_strb)
    else begin $error("read strobes in adjacent cycles"); fail_cnt++; end
  a_wr_space: assert property (@(posedge clk0) disable iff (rst_i) usr_wr_strb |=> !usr_wr_strb)
    else begin $error("write strobes in adjacent cycles"); fail_cnt++; end
  a_rst_dvld: assert property (@(posedge clk0) rst_i |=> !usr_rd_dvld)
    else begin $error("usr_rd_dvld high in reset"); fail_cnt++; end

endmodule

bind qdr_controller qdr_controller_chk u_chk (
  .clk0        (clk0),
  .rst_i       (rst_i),
  .qdr_w_n     (qdr_w_n),
  .qdr_r_n     (qdr_r_n),
  .slot        (u_cmd_issue.slot),
  .usr_rd_strb (usr_rd_strb),
  .usr_wr_strb (usr_wr_strb),
  .phy_rdy     (phy_rdy),
  .usr_rd_dvld (usr_rd_dvld)
);

// File: bench/qdr_controller_tb.sv
`include "qdr_params.svh"

module qdr_controller_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [1:0] OP_WR = 2'd0;
  localparam logic [1:0] OP_RD = 2'd1;
  localparam logic [1:0] OP_RW = 2'd2;

  typedef struct packed {
    logic [1:0]  op;
    logic [21:0] addr;
    logic [71:0] data;
    logic [7:0]  be;
    logic        rnd;      // Data comes from $urandom
    logic        nowait;   // Next read follows without waiting for this one
    logic [71:0] exp;
  } row_s;

  logic        clk0;
  logic        qdr_rst;
  logic        idelay_rdy;
  logic [35:0] qdr_q;
  logic        qdr_cq;
  logic        qdr_cq_n;
  logic        qdr_qvld;
  logic        usr_rd_strb;
  logic        usr_wr_strb;
  logic [21:0] usr_addr;
  logic [71:0] usr_wr_data;
  logic [7:0]  usr_wr_be;
  logic [35:0] qdr_d;
  logic [21:0] qdr_sa;
  logic        qdr_w_n;
  logic        qdr_r_n;
  logic [3:0]  qdr_bw_n;
  logic        qdr_k;
  logic        qdr_k_n;
  logic        qdr_dll_off_n;
  logic        phy_rdy;
  logic        cal_fail;
  logic [3:0]  phy_state_prb;
  logic [71:0] usr_rd_data;
  logic        usr_rd_dvld;

  row_s        rows[$];
  logic [71:0] shadow [logic [21:0]];
  logic [71:0] exp_q[$];
  logic [71:0] exp_w;
  int          err_cnt = 0;
  int          issued = 0;
  int          done = 0;

  qdr_controller u_qdr_controller (.*);

  qdr_sram_model u_sram (
    .clk0 (clk0), .sa (qdr_sa), .w_n (qdr_w_n), .r_n (qdr_r_n),
    .bw_n (qdr_bw_n), .d (qdr_d), .q (qdr_q), .qvld (qdr_qvld)
  );

  initial clk0 = 1'b0;
  always #20 clk0 = ~clk0;

  function automatic row_s mk_row(logic [1:0] op, logic [21:0] a, logic [71:0] d,
                                  logic [7:0] be, logic rnd, logic nowait);
    row_s r;
    r.op = op;
    r.addr = a;
    r.data = d;
    r.be = be;
    r.rnd = rnd;
    r.nowait = nowait;
    r.exp = '0;
    return r;
  endfunction

  // Lane i of the enable guards bits 9i to 9i+8 of the flat word
  function automatic void shadow_write(logic [21:0] a, logic [71:0] d, logic [7:0] be);
    logic [71:0] w;
    w = shadow.exists(a) ? shadow[a] : '0;
    for (int i = 0; i < 8; i++) begin
      if (be[i]) w[9*i +: 9] = d[9*i +: 9];
    end
    shadow[a] = w;
  endfunction

  // Every read row expects completion within 40 cycles
  task automatic wait_reads(int row);
    int n;
    n = 0;
    while (done < issued && n < 40) begin
      @(negedge clk0);
      n++;
    end
    if (done < issued) begin
      $display("Row %0d: read data did not arrive within 40 cycles", row);
      err_cnt++;
    end
  endtask

  task automatic idle(int n);
    repeat (n) @(negedge clk0);
  endtask

  always @(negedge clk0) begin
    if (usr_rd_dvld && phy_rdy) begin
      if (exp_q.size() == 0) begin
        $display("ERR %0t: usr_rd_dvld pulse with no read outstanding", $time);
        err_cnt++;
      end else begin
        exp_w = exp_q.pop_front();
        if (usr_rd_data !== exp_w) begin
          $display("ERR %0t: read data %h, expected %h", $time, usr_rd_data, exp_w);
          err_cnt++;
        end
      end
      done++;
    end
  end

  initial begin
    logic [95:0] rnd_w;
    int          n;
    int          row_err;
    int          tests;
    int          bad;
    tests = 0;
    bad = 0;
    void'($urandom(72));
    qdr_rst = 1'b1;
    idelay_rdy = 1'b1;
    qdr_cq = 1'b0;
    qdr_cq_n = 1'b1;
    usr_rd_strb = 1'b0;
    usr_wr_strb = 1'b0;
    usr_addr = '0;
    usr_wr_data = '0;
    usr_wr_be = '0;

    rows.push_back(mk_row(OP_WR, 22'h000010, 72'h12_3456_789a_bcde_f012, 8'hff, 0, 0));
    rows.push_back(mk_row(OP_WR, 22'h002345, '0, 8'hff, 1, 0));
    rows.push_back(mk_row(OP_WR, 22'h3fffff, 72'hff_0000_ffff_0000_ffff, 8'hff, 0, 0));
    rows.push_back(mk_row(OP_RD, 22'h000010, '0, '0, 0, 0));
    rows.push_back(mk_row(OP_RD, 22'h002345, '0, '0, 0, 0));
    rows.push_back(mk_row(OP_RD, 22'h3fffff, '0, '0, 0, 0));
    rows.push_back(mk_row(OP_RD, 22'h000000, '0, '0, 0, 0));
    rows.push_back(mk_row(OP_WR, 22'h000010, 72'hab_cdef_0123_4567_89ab, 8'ha5, 0, 0));
    rows.push_back(mk_row(OP_RD, 22'h000010, '0, '0, 0, 0));
    rows.push_back(mk_row(OP_RW, 22'h002345, '0, 8'hff, 1, 0));
    rows.push_back(mk_row(OP_RD, 22'h002345, '0, '0, 0, 0));
    rows.push_back(mk_row(OP_RD, 22'h000010, '0, '0, 0, 1));
    rows.push_back(mk_row(OP_RD, 22'h3fffff, '0, '0, 0, 1));
    rows.push_back(mk_row(OP_RD, 22'h000000, '0, '0, 0, 1));
    rows.push_back(mk_row(OP_RD, 22'h002345, '0, '0, 0, 0));

    // Calibration leaves its training word at address 0
    shadow[22'h0] = `QDR_CAL_PATTERN;
    foreach (rows[i]) begin
      if (rows[i].rnd) begin
        rnd_w = {$urandom, $urandom, $urandom};
        rows[i].data = rnd_w[71:0];
      end
      if (rows[i].op != OP_WR) rows[i].exp = shadow[rows[i].addr];
      if (rows[i].op != OP_RD) shadow_write(rows[i].addr, rows[i].data, rows[i].be);
    end

    idle(8);
    row_err = err_cnt;
    if (phy_rdy !== 1'b0 || cal_fail !== 1'b0 || qdr_dll_off_n !== 1'b0) begin
      $display("ERR %0t: outputs not in reset state", $time);
      err_cnt++;
    end
    qdr_rst = 1'b0;
    n = 0;
    while (phy_rdy !== 1'b1 && n < 400) begin
      @(negedge clk0);
      n++;
    end
    if (phy_rdy !== 1'b1) begin
      $display("Init: phy_rdy did not rise within 400 cycles");
      err_cnt++;
    end
    if (cal_fail !== 1'b0 || phy_state_prb !== qdr_pkg::PHY_READY ||
        qdr_dll_off_n !== 1'b1) begin
      $display("ERR %0t: cal_fail %b, state %0d, dll_off_n %b after init", $time, cal_fail,
               phy_state_prb, qdr_dll_off_n);
      err_cnt++;
    end
    // The K pins are looked at in the middle of each clk0 phase
    @(posedge clk0);
    #10;
    if (qdr_k !== 1'b1 || qdr_k_n !== 1'b0) begin
      $display("ERR %0t: qdr_k %b, qdr_k_n %b with clk0 high", $time, qdr_k, qdr_k_n);
      err_cnt++;
    end
    @(negedge clk0);
    #10;
    if (qdr_k !== 1'b0 || qdr_k_n !== 1'b1) begin
      $display("ERR %0t: qdr_k %b, qdr_k_n %b with clk0 low", $time, qdr_k, qdr_k_n);
      err_cnt++;
    end
    @(negedge clk0);
    tests++;
    if (err_cnt != row_err) bad++;
    $display("Init: %s", (err_cnt == row_err) ? "ok" : "FAILED");

    foreach (rows[i]) begin
      row_err = err_cnt;
      if (rows[i].op == OP_RW) begin
        // Strobe where the read goes first, so it must see the old word
        n = 0;
        while (u_qdr_controller.u_cmd_issue.slot !== 1'b1 && n < 4) begin
          @(negedge clk0);
          n++;
        end
        if (u_qdr_controller.u_cmd_issue.slot !== 1'b1) begin
          $display("Row %0d: read slot phase not found within 4 cycles", i);
          err_cnt++;
        end
      end
      usr_addr = rows[i].addr;
      usr_wr_data = rows[i].data;
      usr_wr_be = rows[i].be;
      usr_wr_strb = (rows[i].op != OP_RD);
      usr_rd_strb = (rows[i].op != OP_WR);
      if (rows[i].op != OP_WR) begin
        exp_q.push_back(rows[i].exp);
        issued++;
      end
      @(negedge clk0);
      usr_wr_strb = 1'b0;
      usr_rd_strb = 1'b0;
      if (rows[i].nowait) begin
        idle(1);
      end else begin
        if (rows[i].op != OP_WR) wait_reads(i);
        idle(2);
      end
      tests++;
      if (err_cnt != row_err) bad++;
      $display("Row %0d op %0d addr %h: %s", i, rows[i].op, rows[i].addr,
               (err_cnt == row_err) ? "ok" : "FAILED");
    end

    idle(4);
    if (done != issued || exp_q.size() != 0) begin
      $display("ERR %0t: %0d read pulses for %0d reads", $time, done, issued);
      err_cnt++;
    end
    if (cal_fail !== 1'b0) begin
      $display("ERR %0t: cal_fail went high", $time);
      err_cnt++;
    end
    err_cnt += u_qdr_controller.u_chk.fail_cnt;
    $display("Tests %0d, failed %0d, errors %0d, assertion failures %0d",
             tests, bad, err_cnt, u_qdr_controller.u_chk.fail_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: bench/qdr_sram_model.sv
module qdr_sram_model (
  input  logic        clk0,
  input  logic [21:0] sa,
  input  logic        w_n,
  input  logic        r_n,
  input  logic [3:0]  bw_n,
  input  logic [35:0] d,
  output logic [35:0] q,
  output logic        qvld
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [71:0] mem [logic [21:0]];
  logic        wr_hi;
  logic [21:0] wr_addr;
  logic        rd_s1;
  logic        rd_s2;
  logic        hi_out;
  logic [71:0] rd_w1;
  logic [71:0] rd_w2;
  logic [35:0] hi_q;
  logic [71:0] word;

  // Unwritten locations read back a word built from the whole address
  function automatic logic [71:0] fetch(input logic [21:0] a);
    if (mem.exists(a)) return mem[a];
    return {~{a, a[13:0]}, {a, a[13:0]}};
  endfunction

  function automatic logic [35:0] merge(input logic [35:0] old_w, input logic [35:0] new_w,
                                        input logic [3:0] lane_n);
    logic [35:0] r;
    r = old_w;
    for (int i = 0; i < 4; i++) begin
      if (!lane_n[i]) r[9*i +: 9] = new_w[9*i +: 9];   // Active low byte write
    end
    return r;
  endfunction

  initial begin
    q      = '0;
    qvld   = 1'b0;
    wr_hi  = 1'b0;
    rd_s1  = 1'b0;
    rd_s2  = 1'b0;
    hi_out = 1'b0;
  end

  always @(posedge clk0) begin
    if (wr_hi) begin
      word = fetch(wr_addr);
      word[71:36] = merge(word[71:36], d, bw_n);   // Second beat of the burst
      mem[wr_addr] = word;
    end
    if (w_n === 1'b0) begin
      word = fetch(sa);
      word[35:0] = merge(word[35:0], d, bw_n);
      mem[sa] = word;
      wr_addr <= sa;
    end
    wr_hi <= (w_n === 1'b0);
    rd_s1 <= (r_n === 1'b0);
    rd_w1 <= fetch(sa);
    rd_s2 <= rd_s1;
    rd_w2 <= rd_w1;
    if (rd_s2) begin
      q      <= rd_w2[35:0];
      hi_q   <= rd_w2[71:36];
      qvld   <= 1'b1;
      hi_out <= 1'b1;
    end else if (hi_out) begin
      q      <= hi_q;
      qvld   <= 1'b1;
      hi_out <= 1'b0;
    end else begin
      qvld   <= 1'b0;
      hi_out <= 1'b0;
    end
  end

endmodule

// File: qdr_controller.f
+incdir+rtl
rtl/qdr_pkg.sv
rtl/qdr_phy_init.sv
rtl/qdr_cmd_issue.sv
rtl/qdr_rd_capture.sv
rtl/qdr_controller.sv
bench/qdr_sram_model.sv
bench/qdr_controller_chk.sv
bench/qdr_controller_tb.sv

// File: rtl/qdr_cmd_issue.sv
module qdr_cmd_issue (
  input  logic               clk0,
  input  logic               rst_i,
  input  logic               phy_rdy,
  input  qdr_pkg::qdr_req_s  cal_req,
  input  qdr_pkg::qdr_req_s  usr_req,
  output qdr_pkg::qdr_pins_s pins
);

  qdr_pkg::qdr_req_s  req;
  qdr_pkg::qdr_burst_u wr_data_q;
  qdr_pkg::qdr_be_u   wr_be_q;
  qdr_pkg::qdr_burst_u wr_data_sel;
  qdr_pkg::qdr_be_u   wr_be_sel;
  logic [21:0]        rd_addr_q;
  logic [21:0]        wr_addr_q;
  logic               slot;
  logic               rd_pend;
  logic               wr_pend;
  logic               hi_pend;
  logic               rd_go;
  logic               wr_go;

  assign req = phy_rdy ? usr_req : cal_req;   // Training owns the bus until ready

  // Pins are registered, so a decision here lands in the following slot
  assign rd_go = slot & (req.rd | rd_pend);
  assign wr_go = ~slot & (req.wr | wr_pend);

  assign wr_data_sel = req.wr ? req.data : wr_data_q;
  assign wr_be_sel   = req.wr ? req.be : wr_be_q;

  always_ff @(posedge clk0) begin
    if (rst_i) begin
      slot      <= 1'b0;
      rd_pend   <= 1'b0;
      wr_pend   <= 1'b0;
      hi_pend   <= 1'b0;
      pins.r_n  <= 1'b1;
      pins.w_n  <= 1'b1;
      pins.bw_n <= '1;
    end else begin
      slot     <= ~slot;
      rd_pend  <= req.rd & ~slot;   // Wrong phase, goes out one cycle later
      wr_pend  <= req.wr & slot;
      hi_pend  <= wr_go;
      pins.r_n <= ~rd_go;
      pins.w_n <= ~wr_go;
      if (wr_go) pins.bw_n <= ~wr_be_sel.beats.lo;
      else if (hi_pend) pins.bw_n <= ~wr_be_q.beats.hi;
      else pins.bw_n <= '1;
    end
  end

  always_ff @(posedge clk0) begin
    if (req.rd) rd_addr_q <= req.addr;
    if (req.wr) begin
      wr_addr_q <= req.addr;
      wr_data_q <= req.data;
      wr_be_q   <= req.be;
    end
    if (rd_go) pins.sa <= req.rd ? req.addr : rd_addr_q;
    else if (wr_go) pins.sa <= req.wr ? req.addr : wr_addr_q;
    if (wr_go) pins.d <= wr_data_sel.beats.lo;
    else if (hi_pend) pins.d <= wr_data_q.beats.hi;   // Second beat of the burst
  end

endmodule

// File: rtl/qdr_controller.sv
`include "qdr_params.svh"

module qdr_controller (
  input  logic                     clk0,
  input  logic                     qdr_rst,
  input  logic                     idelay_rdy,
  input  logic [`QDR_DATA_W-1:0]   qdr_q,
  input  logic                     qdr_cq,   // Echo clocks are not needed at single rate
  input  logic                     qdr_cq_n,
  input  logic                     qdr_qvld,
  input  logic                     usr_rd_strb,
  input  logic                     usr_wr_strb,
  input  logic [`QDR_ADDR_W-1:0]   usr_addr,
  input  logic [2*`QDR_DATA_W-1:0] usr_wr_data,
  input  logic [2*`QDR_BW_W-1:0]   usr_wr_be,
  output logic [`QDR_DATA_W-1:0]   qdr_d,
  output logic [`QDR_ADDR_W-1:0]   qdr_sa,
  output logic                     qdr_w_n,
  output logic                     qdr_r_n,
  output logic [`QDR_BW_W-1:0]     qdr_bw_n,
  output logic                     qdr_k,
  output logic                     qdr_k_n,
  output logic                     qdr_dll_off_n,
  output logic                     phy_rdy,
  output logic                     cal_fail,
  output logic [3:0]               phy_state_prb,
  output logic [2*`QDR_DATA_W-1:0] usr_rd_data,
  output logic                     usr_rd_dvld
);

  logic                    rst_i;
  qdr_pkg::qdr_req_s       cal_req;
  qdr_pkg::qdr_req_s       usr_req;
  qdr_pkg::qdr_pins_s      pins;
  qdr_pkg::qdr_burst_u     rd_data;
  qdr_pkg::qdr_phy_state_e phy_state;

  assign rst_i = qdr_rst | ~idelay_rdy;   // Held until the delay elements are stable

  assign usr_req.rd        = usr_rd_strb & phy_rdy;
  assign usr_req.wr        = usr_wr_strb & phy_rdy;
  assign usr_req.addr      = usr_addr;
  assign usr_req.data.flat = usr_wr_data;
  assign usr_req.be.flat   = usr_wr_be;

  qdr_phy_init u_phy_init (
    .clk0      (clk0),
    .rst_i     (rst_i),
    .cap_data  (rd_data),
    .cap_dvld  (usr_rd_dvld),
    .cal_req   (cal_req),
    .dll_off_n (qdr_dll_off_n),
    .phy_rdy   (phy_rdy),
    .cal_fail  (cal_fail),
    .state     (phy_state)
  );

  qdr_cmd_issue u_cmd_issue (
    .clk0    (clk0),
    .rst_i   (rst_i),
    .phy_rdy (phy_rdy),
    .cal_req (cal_req),
    .usr_req (usr_req),
    .pins    (pins)
  );

  qdr_rd_capture u_rd_capture (
    .clk0     (clk0),
    .rst_i    (rst_i),
    .qdr_q    (qdr_q),
    .qdr_qvld (qdr_qvld),
    .rd_data  (rd_data),
    .rd_dvld  (usr_rd_dvld)
  );

  assign qdr_sa        = pins.sa;
  assign qdr_w_n       = pins.w_n;
  assign qdr_r_n       = pins.r_n;
  assign qdr_bw_n      = pins.bw_n;
  assign qdr_d         = pins.d;
  assign qdr_k         = clk0;
  assign qdr_k_n       = ~clk0;
  assign phy_state_prb = phy_state;
  assign usr_rd_data   = rd_data.flat;

endmodule

// File: rtl/qdr_params.svh
`ifndef QDR_PARAMS_SVH
`define QDR_PARAMS_SVH

// Pin widths of one beat
`define QDR_DATA_W 36
`define QDR_BW_W 4
`define QDR_ADDR_W 22

// Init wait counts in clk0 cycles
`define QDR_DLL_WAIT 32
`define QDR_LOCK_WAIT 64

// Training attempts before calibration gives up
`define QDR_CAL_TRIES 3

// Training word written to address 0 and read back
`define QDR_CAL_PATTERN 72'h00_abcd_ef12_3456_7890

`endif

// File: rtl/qdr_phy_init.sv
`include "qdr_params.svh"

module qdr_phy_init (
  input  logic                    clk0,
  input  logic                    rst_i,
  input  qdr_pkg::qdr_burst_u     cap_data,
  input  logic                    cap_dvld,
  output qdr_pkg::qdr_req_s       cal_req,
  output logic                    dll_off_n,
  output logic                    phy_rdy,
  output logic                    cal_fail,
  output qdr_pkg::qdr_phy_state_e state
);

  localparam int CAL_GAP = 4;   // Lets the training write settle before the read-back
  localparam int WDOG = 16;

  logic [7:0] cnt;
  logic [1:0] tries;
  logic       cal_ok;

  assign cal_ok = (cap_data.flat == `QDR_CAL_PATTERN);

  always_ff @(posedge clk0) begin
    if (rst_i) begin
      state <= qdr_pkg::PHY_RESET;
      cnt   <= '0;
      tries <= '0;
    end else begin
      cnt <= cnt + 8'd1;
      case (state)
        qdr_pkg::PHY_RESET: begin
          state <= qdr_pkg::PHY_DLL;
          cnt   <= '0;
        end
        qdr_pkg::PHY_DLL: begin
          if (cnt == 8'(`QDR_DLL_WAIT - 1)) begin
            state <= qdr_pkg::PHY_LOCK;   // DLL released from here on
            cnt   <= '0;
          end
        end
        qdr_pkg::PHY_LOCK: begin
          if (cnt == 8'(`QDR_LOCK_WAIT - 1)) begin
            state <= qdr_pkg::PHY_CAL_WR;
            cnt   <= '0;
          end
        end
        qdr_pkg::PHY_CAL_WR: begin
          if (cnt == 8'(CAL_GAP - 1)) begin
            state <= qdr_pkg::PHY_CAL_RD;
          end
        end
        qdr_pkg::PHY_CAL_RD: begin
          state <= qdr_pkg::PHY_CAL_CHK;
          cnt   <= '0;
        end
        qdr_pkg::PHY_CAL_CHK: begin
          if (cap_dvld || cnt == 8'(WDOG - 1)) begin
            cnt <= '0;
            if (cap_dvld && cal_ok) begin
              state <= qdr_pkg::PHY_READY;
            end else if (tries == 2'(`QDR_CAL_TRIES - 1)) begin
              state <= qdr_pkg::PHY_FAIL;
            end else begin
              tries <= tries + 2'd1;
              state <= qdr_pkg::PHY_CAL_WR;
            end
          end
        end
        qdr_pkg::PHY_READY, qdr_pkg::PHY_FAIL: cnt <= cnt;   // Terminal states
        default: state <= qdr_pkg::PHY_RESET;
      endcase
    end
  end

  // Write strobe on the first cycle of CAL_WR, read strobe for the single CAL_RD cycle
  always_comb begin
    cal_req           = '0;
    cal_req.wr        = (state == qdr_pkg::PHY_CAL_WR) && (cnt == 8'd0);
    cal_req.rd        = (state == qdr_pkg::PHY_CAL_RD);
    cal_req.addr      = '0;
    cal_req.data.flat = `QDR_CAL_PATTERN;
    cal_req.be.flat   = '1;
  end

  assign dll_off_n = (state != qdr_pkg::PHY_RESET) && (state != qdr_pkg::PHY_DLL);
  assign phy_rdy   = (state == qdr_pkg::PHY_READY);
  assign cal_fail  = (state == qdr_pkg::PHY_FAIL);

endmodule

// File: rtl/qdr_pkg.sv
`include "qdr_params.svh"

package qdr_pkg;

  typedef struct packed {
    logic [`QDR_DATA_W-1:0] hi;
    logic [`QDR_DATA_W-1:0] lo;   // First beat on the pins
  } qdr_beats_s;

  typedef union packed {
    logic [2*`QDR_DATA_W-1:0] flat;
    qdr_beats_s               beats;
  } qdr_burst_u;

  typedef struct packed {
    logic [`QDR_BW_W-1:0] hi;
    logic [`QDR_BW_W-1:0] lo;
  } qdr_be_beats_s;

  typedef union packed {
    logic [2*`QDR_BW_W-1:0] flat;
    qdr_be_beats_s          beats;
  } qdr_be_u;

  typedef struct packed {
    logic [`QDR_ADDR_W-1:0] sa;
    logic                   w_n;
    logic                   r_n;
    logic [`QDR_BW_W-1:0]   bw_n;
    logic [`QDR_DATA_W-1:0] d;
  } qdr_pins_s;

  typedef struct packed {
    logic                   rd;
    logic                   wr;
    logic [`QDR_ADDR_W-1:0] addr;
    qdr_burst_u             data;
    qdr_be_u                be;
  } qdr_req_s;

  typedef enum logic [3:0] {
    PHY_RESET   = 4'd0,
    PHY_DLL     = 4'd1,
    PHY_LOCK    = 4'd2,
    PHY_CAL_WR  = 4'd3,
    PHY_CAL_RD  = 4'd4,
    PHY_CAL_CHK = 4'd5,
    PHY_READY   = 4'd6,
    PHY_FAIL    = 4'd7
  } qdr_phy_state_e;

endpackage

// File: rtl/qdr_rd_capture.sv
`include "qdr_params.svh"

module qdr_rd_capture (
  input  logic                   clk0,
  input  logic                   rst_i,
  input  logic [`QDR_DATA_W-1:0] qdr_q,
  input  logic                   qdr_qvld,
  output qdr_pkg::qdr_burst_u    rd_data,
  output logic                   rd_dvld
);

  logic                   beat;   // Set once the lo beat is held
  logic [`QDR_DATA_W-1:0] lo_q;

  always_ff @(posedge clk0) begin
    if (rst_i) begin
      beat    <= 1'b0;
      rd_dvld <= 1'b0;
    end else begin
      rd_dvld <= qdr_qvld & beat;
      if (qdr_qvld) begin
        beat <= ~beat;
      end
    end
  end

  // Back-to-back bursts simply keep alternating lo and hi
  always_ff @(posedge clk0) begin
    if (qdr_qvld && !beat) begin
      lo_q <= qdr_q;
    end
    if (qdr_qvld && beat) begin
      rd_data.beats.lo <= lo_q;
      rd_data.beats.hi <= qdr_q;
    end
  end

endmodule
